// ==== Makefile ====
# Verilator build and run for the TV display slave

VERILATOR ?= verilator
TOP       ?= tv_subsys_tb
RTL_TOP   ?= tv_subsys
FILELIST  ?= tv_subsys.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
ERR_LIMIT ?= 100
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	$(BUILD_DIR)/V$(TOP) +verilator+error+limit+$(ERR_LIMIT) | tee $(LOG)
	@grep -qF "*** TEST PASSED ***" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== logic/hz60_timer.sv ====
// Vertical tick timer

`timescale 1ns/1ps

`include "tv_defines.svh"

module hz60_timer (
   input  logic clk,
   input  logic reset,
   output logic tick
);

   localparam int PERIOD = `TV_TICK_CYCLES;
   localparam int CW     = $clog2(PERIOD + 1);

   // Cycle index within the period, 1 in the first cycle after reset
   logic [CW-1:0] cnt;

   //////////////////////////////////////////////////////////////////////
   // Counter runs 1..PERIOD and wraps

   always_ff @(posedge clk) begin
      if (reset) begin
         cnt  <= CW'(1);
         tick <= 1'b0;
      end else begin
         if (cnt == CW'(PERIOD))
            cnt <= CW'(1);
         else
            cnt <= cnt + CW'(1);
         // Registered so tick is high while cnt == PERIOD
         tick <= cnt == CW'(PERIOD - 1);
      end
   end

endmodule

// ==== logic/tv_bus_fsm.sv ====
// TV bus slave handshake

`timescale 1ns/1ps

`include "tv_defines.svh"

module tv_bus_fsm import tv_pkg::*; (
   input  logic         clk,
   input  logic         reset,
   input  logic         req,
   input  bus_req_t     bus,
   input  vram_rsp_t    vram_rsp,
   output logic         ack,
   output logic         decode,
   output logic         vram_req,
   output vram_cmd_t    vram_cmd,
   output logic         reg_wr,
   output logic         reg_rd,
   output logic [31:0]  reg_wdata
);

   slave_state_e state;
   slave_state_e state_nx;
   logic         in_fb;
   logic         in_reg;

   //////////////////////////////////////////////////////////////////////
   // Address decode

   assign in_fb  = bus.addr[21:15] == `TV_FB_BASE;
   assign in_reg = bus.addr[21:3] == `TV_REG_BASE;

   // Only while the master is asking
   assign decode = req && (in_fb || in_reg);

   //////////////////////////////////////////////////////////////////////
   // Slave FSM

   always_comb begin
      state_nx = state;
      case (state)
         IDLE: begin
            // Framebuffer goes through VRAM, registers answer at once
            if (req && in_fb)
               state_nx = bus.write ? WRITE : READ;
            else if (req && in_reg)
               state_nx = DONE;
         end
         WRITE: if (vram_rsp.done) state_nx = DONE;
         READ:  if (vram_rsp.ready) state_nx = DONE;
         // Hold ack until req drops
         DONE:  if (!req) state_nx = IDLE;
         default: state_nx = IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset)
         state <= IDLE;
      else
         state <= state_nx;
   end

   assign ack = state == DONE;

   // Register strobes, one cycle, in the IDLE cycle that sees req
   assign reg_wr    = (state == IDLE) && req && in_reg && bus.write;
   assign reg_rd    = (state == IDLE) && req && in_reg && !bus.write;
   assign reg_wdata = bus.wdata;

   // VRAM command straight off the held bus fields
   assign vram_req        = (state == WRITE) || (state == READ);
   assign vram_cmd.offset = bus.addr[`TV_VRAM_AW-1:0];
   assign vram_cmd.wdata  = bus.wdata;
   assign vram_cmd.write  = state == WRITE;

endmodule

// ==== logic/tv_ctl_regs.sv ====
// TV control and status registers

`timescale 1ns/1ps

module tv_ctl_regs import tv_pkg::*; (
   input  logic         clk,
   input  logic         reset,
   input  logic         reg_wr,
   input  logic         reg_rd,
   input  logic [31:0]  reg_wdata,
   input  logic         tick,
   input  vram_rsp_t    vram_rsp,
   output logic [31:0]  rdata,
   output logic         interrupt
);

   logic int_en;
   logic int_flag;

   //////////////////////////////////////////////////////////////////////
   // Interrupt enable and flag

   // Bit 3 is the enable, bit 4 written as 1 clears the flag
   always_ff @(posedge clk) begin
      if (reset)
         int_en <= 1'b0;
      else if (reg_wr)
         int_en <= reg_wdata[3];
   end

   always_ff @(posedge clk) begin
      if (reset)
         int_flag <= 1'b0;
      else if (tick)
         // Tick wins over a clear in the same cycle
         int_flag <= 1'b1;
      else if (reg_wr && reg_wdata[4])
         int_flag <= 1'b0;
   end

   assign interrupt = int_en & int_flag;

   //////////////////////////////////////////////////////////////////////
   // Read data back to the bus

   always_ff @(posedge clk) begin
      if (reset)
         rdata <= '0;
      else if (reg_rd)
         rdata <= {27'b0, int_flag, int_en, 3'b0};
      else if (vram_rsp.ready)
         // Framebuffer read result
         rdata <= vram_rsp.rdata;
   end

   // rdata stays put while ack is held
   // so a long wait by the master
   // sees the same word

endmodule

// ==== logic/tv_defines.svh ====
// TV slave parameters
`ifndef TV_DEFINES_SVH
`define TV_DEFINES_SVH

// Framebuffer window tag, addr[21:15] == octal 170
`define TV_FB_BASE      7'o170

// Register block tag, octal 17377760 >> 3 compared against addr[21:3]
`define TV_REG_BASE     19'o1737776

// VRAM geometry
`define TV_VRAM_AW      15
`define TV_VRAM_DEPTH   (1 << `TV_VRAM_AW)

// Cycles from first vram_req to the ready or done pulse
`define TV_VRAM_LAT     3

// Vertical tick period, short for simulation
`define TV_TICK_CYCLES  200

`endif

// ==== logic/tv_pkg.sv ====
// TV slave types

package tv_pkg;

   `include "tv_defines.svh"

   // CPU side request, held stable by the master until ack
   typedef struct packed {
      logic [21:0] addr;
      logic [31:0] wdata;
      logic        write;
   } bus_req_t;

   // Command to the VRAM controller
   typedef struct packed {
      logic [`TV_VRAM_AW-1:0] offset;
      logic [31:0]            wdata;
      logic                   write;
   } vram_cmd_t;

   // VRAM answer, ready for reads and done for writes
   typedef struct packed {
      logic [31:0] rdata;
      logic        ready;
      logic        done;
   } vram_rsp_t;

   // Bus slave FSM states
   typedef enum logic [1:0] {IDLE, WRITE, READ, DONE} slave_state_e;

endpackage

// ==== logic/tv_subsys.sv ====
// TV display bus slave top

`timescale 1ns/1ps

module tv_subsys import tv_pkg::*; (
   input  logic         clk,
   input  logic         reset,
   input  logic         req,
   input  bus_req_t     bus,
   output logic         ack,
   output logic         decode,
   output logic [31:0]  rdata,
   output logic         interrupt
);

   // Slave to VRAM
   logic         vram_req;
   vram_cmd_t    vram_cmd;
   vram_rsp_t    vram_rsp;

   // Slave to registers
   logic         reg_wr;
   logic         reg_rd;
   logic [31:0]  reg_wdata;
   logic         tick;

   //////////////////////////////////////////////////////////////////////
   // Bus side

   tv_bus_fsm u_tv_bus_fsm (
      .clk       (clk),
      .reset     (reset),
      .req       (req),
      .bus       (bus),
      .vram_rsp  (vram_rsp),
      .ack       (ack),
      .decode    (decode),
      .vram_req  (vram_req),
      .vram_cmd  (vram_cmd),
      .reg_wr    (reg_wr),
      .reg_rd    (reg_rd),
      .reg_wdata (reg_wdata)
   );

   //////////////////////////////////////////////////////////////////////
   // Timer, registers and memory

   hz60_timer u_hz60_timer (
      .clk   (clk),
      .reset (reset),
      .tick  (tick)
   );

   tv_ctl_regs u_tv_ctl_regs (
      .clk       (clk),
      .reset     (reset),
      .reg_wr    (reg_wr),
      .reg_rd    (reg_rd),
      .reg_wdata (reg_wdata),
      .tick      (tick),
      .vram_rsp  (vram_rsp),
      .rdata     (rdata),
      .interrupt (interrupt)
   );

   vram_ctl u_vram_ctl (
      .clk      (clk),
      .reset    (reset),
      .vram_req (vram_req),
      .vram_cmd (vram_cmd),
      .vram_rsp (vram_rsp)
   );

endmodule

// ==== logic/vram_ctl.sv ====
// VRAM array controller

`timescale 1ns/1ps

`include "tv_defines.svh"

module vram_ctl import tv_pkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  logic       vram_req,
   input  vram_cmd_t  vram_cmd,
   output vram_rsp_t  vram_rsp
);

   localparam int LAT = `TV_VRAM_LAT;
   localparam int CW  = $clog2(LAT + 1);

   // Local sequencing of one access
   typedef enum logic [1:0] {V_IDLE, V_BUSY, V_WAIT} vram_phase_e;

   vram_phase_e    phase;
   logic [CW-1:0]  cnt;
   logic           expire;
   logic           ready_q;
   logic           done_q;
   logic [31:0]    rd_q;
   logic [31:0]    mem [`TV_VRAM_DEPTH];

   //////////////////////////////////////////////////////////////////////
   // Latency count

   // Last counted cycle of the access
   assign expire = vram_req && (phase != V_WAIT) && (cnt == CW'(LAT - 1));

   always_ff @(posedge clk) begin
      if (reset) begin
         phase   <= V_IDLE;
         cnt     <= '0;
         ready_q <= 1'b0;
         done_q  <= 1'b0;
      end else begin
         ready_q <= 1'b0;
         done_q  <= 1'b0;
         case (phase)
            V_IDLE, V_BUSY: begin
               if (!vram_req) begin
                  phase <= V_IDLE;
                  cnt   <= '0;
               end else if (expire) begin
                  // Answer next cycle, then wait for req to drop
                  phase   <= V_WAIT;
                  cnt     <= '0;
                  ready_q <= !vram_cmd.write;
                  done_q  <= vram_cmd.write;
               end else begin
                  phase <= V_BUSY;
                  cnt   <= cnt + CW'(1);
               end
            end
            V_WAIT: if (!vram_req) phase <= V_IDLE;
            default: phase <= V_IDLE;
         endcase
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Array access at the end of the count

   always_ff @(posedge clk) begin
      if (expire) begin
         if (vram_cmd.write)
            mem[vram_cmd.offset] <= vram_cmd.wdata;
         else
            rd_q <= mem[vram_cmd.offset];
      end
   end

   assign vram_rsp.rdata = rd_q;
   assign vram_rsp.ready = ready_q;
   assign vram_rsp.done  = done_q;

endmodule

// ==== tv_subsys.f ====
+incdir+logic
logic/tv_pkg.sv
logic/tv_bus_fsm.sv
logic/hz60_timer.sv
logic/tv_ctl_regs.sv
logic/vram_ctl.sv
logic/tv_subsys.sv
verification/tv_subsys_chk.sv
verification/tv_subsys_tb.sv

// ==== verification/tv_subsys_chk.sv ====
// TV slave handshake assertions

`timescale 1ns/1ps

module tv_subsys_chk (
   input logic clk,
   input logic reset,
   input logic req,
   input logic ack
);

   // Failed assertions, read by the testbench at the end
   int unsigned fail_count = 0;

   // Slave comes out of reset idle
   ack_low_after_reset: assert property (@(posedge clk) $fell(reset) |-> !ack)
      else begin
         fail_count++;
         $error("ack high in the first cycle after reset");
      end

   // ack only answers a request that was present
   ack_needs_req: assert property (@(posedge clk) disable iff (reset)
      $rose(ack) |-> $past(req))
      else begin
         fail_count++;
         $error("ack rose while req was low");
      end

   // Back-pressure, ack held for as long as req
   ack_held: assert property (@(posedge clk) disable iff (reset) ack && req |=> ack)
      else begin
         fail_count++;
         $error("ack fell while req stayed high");
      end

endmodule

// ==== verification/tv_subsys_tb.sv ====
// TV slave testbench

`timescale 1ns/1ps

`include "tv_defines.svh"

module tv_subsys_tb import tv_pkg::*; ();

   localparam int TIMEOUT = 40;
   localparam int NWR     = 16;

   logic         clk;
   logic         reset;
   logic         req;
   bus_req_t     bus;
   logic         ack;
   logic         decode;
   logic [31:0]  rdata;
   logic         interrupt;

   // Reference model
   logic [31:0]  vram_model [logic [14:0]];
   logic [14:0]  offs [$];
   int unsigned  cycle;
   logic         m_en;
   logic         m_flag;
   logic         wr_pend;
   logic         rd_pend;
   logic [31:0]  pend_data;
   logic [31:0]  exp_reg;

   int           errors;
   int           n_tests;
   int           n_fail;

   tv_subsys u_tv_subsys (
      .clk       (clk),
      .reset     (reset),
      .req       (req),
      .bus       (bus),
      .ack       (ack),
      .decode    (decode),
      .rdata     (rdata),
      .interrupt (interrupt)
   );

   bind tv_subsys tv_subsys_chk u_tv_subsys_chk (
      .clk   (clk),
      .reset (reset),
      .req   (req),
      .ack   (ack)
   );

   always #50 clk = ~clk;

   //////////////////////////////////////////////////////////////////////
   // Model of enable, flag and tick

   always @(posedge clk) begin
      if (reset) begin
         cycle  = 0;
         m_en   = 1'b0;
         m_flag = 1'b0;
      end else begin
         cycle = cycle + 1;
         // Read strobe sees the registers before this edge
         if (rd_pend)
            exp_reg = {27'b0, m_flag, m_en, 3'b0};
         if (wr_pend)
            m_en = pend_data[3];
         // Tick beats a clear in the same cycle
         if (cycle % `TV_TICK_CYCLES == 0)
            m_flag = 1'b1;
         else if (wr_pend && pend_data[4])
            m_flag = 1'b0;
      end
      wr_pend = 1'b0;
      rd_pend = 1'b0;
   end

   // Interrupt compared every cycle, mid period
   always @(negedge clk) begin
      if (!reset && interrupt !== (m_en & m_flag)) begin
         $display("MISMATCH at %0t ns: interrupt = %b, expected %b",
                  $time, interrupt, m_en & m_flag);
         errors++;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Helpers

   function automatic logic is_reg_addr(input logic [21:0] adr);
      return adr[21:3] == `TV_REG_BASE;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("MISMATCH at %0t ns: %s = %h, expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   // One four-phase transfer, req held hold cycles past ack
   task automatic access(input logic [21:0] adr, input logic [31:0] wd, input logic wr,
                         input int hold, output logic [31:0] data);
      int n;
      @(posedge clk);
      #1;
      req       = 1'b1;
      bus.addr  = adr;
      bus.wdata = wd;
      bus.write = wr;
      if (is_reg_addr(adr)) begin
         wr_pend   = wr;
         rd_pend   = !wr;
         pend_data = wd;
      end
      for (n = 0; n < TIMEOUT; n++) begin
         @(negedge clk);
         // Mapped address, decode follows req
         if (decode !== 1'b1) begin
            $display("MISMATCH at %0t ns: decode = %b, expected 1", $time, decode);
            errors++;
         end
         if (ack)
            break;
      end
      if (!ack) begin
         $display("ERROR at %0t ns: no ack for address %o", $time, adr);
         errors++;
      end
      data = rdata;
      for (n = 0; n < hold; n++) begin
         @(negedge clk);
         if (!ack) begin
            $display("ERROR at %0t ns: ack dropped while req was held", $time);
            errors++;
         end
         check_value("rdata", rdata, data);
      end
      @(posedge clk);
      #1;
      req = 1'b0;
      for (n = 0; n < 2; n++) begin
         @(negedge clk);
         if (!ack)
            break;
      end
      if (ack) begin
         $display("ERROR at %0t ns: ack still high two cycles after req fell", $time);
         errors++;
      end
   endtask

   task automatic report(input string name, input int start_errs);
      n_tests++;
      if (errors == start_errs)
         $display("%-26s ok", name);
      else begin
         n_fail++;
         $display("%-26s failed with %0d errors", name, errors - start_errs);
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Test sequence

   initial begin
      int          start;
      int          n;
      logic [31:0] rnd;
      logic [31:0] rd;
      logic [21:0] adr;
      logic [14:0] off;
      clk       = 1'b0;
      reset     = 1'b1;
      req       = 1'b0;
      bus       = '0;
      wr_pend   = 1'b0;
      rd_pend   = 1'b0;
      pend_data = '0;
      exp_reg   = '0;
      errors    = 0;
      n_tests   = 0;
      n_fail    = 0;
      void'($urandom(35));
      repeat (2) @(posedge clk);
      #1;
      reset = 1'b0;

      // Framebuffer writes, then read back
      start = errors;
      repeat (NWR) begin
         rnd = $urandom;
         off = rnd[14:0];
         rnd = $urandom;
         access({`TV_FB_BASE, off}, rnd, 1'b1, 0, rd);
         vram_model[off] = rnd;
         offs.push_back(off);
      end
      foreach (offs[i]) begin
         access({`TV_FB_BASE, offs[i]}, '0, 1'b0, 0, rd);
         check_value("rdata", rd, vram_model[offs[i]]);
      end
      report("framebuffer write/read", start);

      // Enable bit through the control register, bit 4 left clear
      start = errors;
      rnd    = $urandom;
      rnd[4] = 1'b0;
      access({`TV_REG_BASE, rnd[7:5]}, rnd, 1'b1, 0, rd);
      rnd = $urandom;
      access({`TV_REG_BASE, rnd[2:0]}, '0, 1'b0, 0, rd);
      check_value("rdata", rd, exp_reg);
      report("control register", start);

      // Enable, wait for a tick, then clear the flag
      start = errors;
      access({`TV_REG_BASE, 3'd0}, 32'h0000_0008, 1'b1, 0, rd);
      for (n = 0; n < 2 * `TV_TICK_CYCLES; n++) begin
         @(negedge clk);
         if (interrupt)
            break;
      end
      if (!interrupt) begin
         $display("ERROR at %0t ns: interrupt never asserted after a tick", $time);
         errors++;
      end
      access({`TV_REG_BASE, 3'd1}, 32'h0000_0018, 1'b1, 0, rd);
      access({`TV_REG_BASE, 3'd2}, '0, 1'b0, 0, rd);
      check_value("rdata", rd, exp_reg);
      report("interrupt", start);

      // Unmapped write aliasing a written offset
      start = errors;
      rnd = $urandom;
      adr = {rnd[31:25], offs[0]};
      while (adr[21:15] == `TV_FB_BASE || is_reg_addr(adr)) begin
         rnd = $urandom;
         adr[21:15] = rnd[6:0];
      end
      @(posedge clk);
      #1;
      req       = 1'b1;
      bus.addr  = adr;
      bus.wdata = $urandom;
      bus.write = 1'b1;
      for (n = 0; n < TIMEOUT; n++) begin
         @(negedge clk);
         if (decode || ack) begin
            $display("ERROR at %0t ns: unmapped address %o answered", $time, adr);
            errors++;
            break;
         end
      end
      @(posedge clk);
      #1;
      req = 1'b0;
      access({`TV_FB_BASE, offs[0]}, '0, 1'b0, 0, rd);
      check_value("rdata", rd, vram_model[offs[0]]);
      report("unmapped address", start);

      // Master holds req past ack
      start = errors;
      repeat (8) begin
         rnd = $urandom;
         off = offs[rnd % NWR];
         rnd = $urandom;
         access({`TV_FB_BASE, off}, '0, 1'b0, 1 + int'(rnd % 10), rd);
         check_value("rdata", rd, vram_model[off]);
      end
      report("back-pressure", start);

      n = errors + int'(u_tv_subsys.u_tv_subsys_chk.fail_count);
      $display("Summary: %0d tests, %0d failed, %0d check errors, %0d assertion failures",
               n_tests, n_fail, errors, u_tv_subsys.u_tv_subsys_chk.fail_count);
      if (n == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule
